// ==== hdl/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath widths
`define RV_XLEN 64
`define RV_ILEN 32
`define RV_PC_W 32

// Memory-mapped peripheral addresses
`define RV_KEY_BASE 64'h0000_0000_8000_0010 // Key register, read clears pending
`define RV_ART_BASE 64'h0000_0000_8000_0000 // Art FIFO push port

// Art FIFO depth, also the starting credit count
`define RV_ART_DEPTH 4

// Machine CSR numbers
`define RV_CSR_MSTATUS 12'h300
`define RV_CSR_MIE     12'h304
`define RV_CSR_MTVEC   12'h305
`define RV_CSR_MEPC    12'h341
`define RV_CSR_MCAUSE  12'h342
`define RV_CSR_MIP     12'h344

// Machine external interrupt cause
`define RV_MCAUSE_MEI 64'h8000_0000_0000_000B

`endif

// ==== hdl/rv_pkg.sv ====
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    // Data word of the register file and bus
    typedef logic [`RV_XLEN-1:0] xword_t;

    // Raw instruction as fetched
    typedef logic [`RV_ILEN-1:0] instr_t;

    // Fetch address
    typedef logic [`RV_PC_W-1:0] pc_t;

    typedef logic [4:0] reg_idx_t;  // x0..x31
    typedef logic [11:0] csr_addr_t; // 12-bit CSR space

    // Must hold every value from 0 up to the FIFO depth
    typedef logic [$clog2(`RV_ART_DEPTH + 1)-1:0] credit_t;

    // Interrupt service sequencer states
    typedef enum logic [2:0] {
        IRQ_IDLE,        // Waiting for a serviceable request
        IRQ_READ,        // Key register read strobe
        IRQ_WAIT_CREDIT, // Read data arrives, then wait for art space
        IRQ_WRITE,       // Push key value into art FIFO
        IRQ_ENTER        // Trap entry pulse
    } irq_state_t;

endpackage

`default_nettype wire

// ==== hdl/rv_core.sv ====
`default_nettype none

module rv_core (
    input  wire               clk,
    input  wire               reset,       // Active low
    input  wire rv_pkg::instr_t instruction, // Combinational fetch data for pc
    input  wire               stall,
    input  wire               trap_enter,
    input  wire rv_pkg::pc_t    mtvec,
    input  wire rv_pkg::pc_t    mepc,
    input  wire rv_pkg::xword_t csr_rdata,
    input  wire rv_pkg::reg_idx_t dbg_addr,
    output rv_pkg::pc_t         pc,
    output rv_pkg::pc_t         ir_pc,
    output logic                can_trap,
    output logic                csr_we,
    output rv_pkg::csr_addr_t   csr_addr,
    output rv_pkg::xword_t      csr_wdata,
    output logic                mret,
    output rv_pkg::xword_t      dbg_data,
    output logic                heartbeat
);

    rv_pkg::instr_t   ir;      // Instruction under execution
    logic             bubble;  // ir holds a squashed fetch
    rv_pkg::xword_t   regs [32];

    rv_pkg::reg_idx_t rd;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::xword_t   rs1_val;
    rv_pkg::xword_t   rs2_val;
    rv_pkg::xword_t   imm_i;
    rv_pkg::xword_t   imm_u;
    logic             exec;    // ir retires this cycle
    logic             is_csrrw;
    logic             is_mret;
    logic             wb_en;
    rv_pkg::xword_t   wb_data;

    assign rd  = ir[11:7];
    assign rs1 = ir[19:15];
    assign rs2 = ir[24:20];

    // x0 is hard zero on every read port
    assign rs1_val  = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val  = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign dbg_data = (dbg_addr == 5'd0) ? '0 : regs[dbg_addr];

    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0}; // RV64 sign extension

    assign exec     = !stall && !bubble;
    assign can_trap = !bubble;  // Keeps trap entry off a squashed slot

    // Decode, anything unmatched is a no-op
    always_comb begin
        is_csrrw = 1'b0;
        is_mret  = 1'b0;
        wb_en    = 1'b0;
        wb_data  = '0;
        casez (ir)
            32'b???????_?????_?????_???_?????_0110111: begin // LUI
                wb_en   = 1'b1;
                wb_data = imm_u;
            end
            32'b???????_?????_?????_000_?????_0010011: begin // ADDI
                wb_en   = 1'b1;
                wb_data = rs1_val + imm_i;
            end
            32'b0000000_?????_?????_000_?????_0110011: begin // ADD
                wb_en   = 1'b1;
                wb_data = rs1_val + rs2_val;
            end
            32'b???????_?????_?????_001_?????_1110011: begin // CSRRW
                is_csrrw = 1'b1;
                wb_en    = 1'b1;
                wb_data  = csr_rdata; // Old CSR value
            end
            32'b0011000_00010_00000_000_00000_1110011: begin // MRET
                is_mret = 1'b1;
            end
            default: ;
        endcase
    end

    assign csr_we    = exec && is_csrrw;
    assign csr_addr  = ir[31:20];
    assign csr_wdata = rs1_val;
    assign mret      = exec && is_mret;

    // Fetch, pc and bubble
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc        <= '0;
            ir        <= '0; // Decodes as a no-op
            ir_pc     <= '0;
            bubble    <= 1'b0;
            heartbeat <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat; // Runs through stalls
            if (trap_enter) begin
                pc     <= mtvec; // ir stays, its address went to mepc
                bubble <= 1'b1;
            end else if (!stall) begin
                ir    <= instruction;
                ir_pc <= pc;
                if (bubble) begin
                    bubble <= 1'b0;  // Drop the wrong-path fetch
                    pc     <= pc + 32'd4;
                end else if (is_mret) begin
                    pc     <= mepc;
                    bubble <= 1'b1;
                end else begin
                    pc <= pc + 32'd4;
                end
            end
        end
    end

    // Register file write port
    always_ff @(posedge clk) begin
        if (exec && wb_en && rd != 5'd0)
            regs[rd] <= wb_data;
    end

endmodule

`default_nettype wire

// ==== hdl/rv_csr.sv ====
`default_nettype none

`include "rv_config.svh"

module rv_csr (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 csr_we,
    input  wire rv_pkg::csr_addr_t csr_addr,
    input  wire rv_pkg::xword_t csr_wdata,
    input  wire                 mret,
    input  wire                 trap_enter,
    input  wire rv_pkg::pc_t    ir_pc,       // Address of the instruction not run
    input  wire                 key_pending,
    output rv_pkg::xword_t      csr_rdata,
    output rv_pkg::pc_t         mtvec,
    output rv_pkg::pc_t         mepc,
    output logic                irq_req
);

    logic           mstatus_mie;
    logic           mstatus_mpie;
    logic           mie_meie;
    rv_pkg::xword_t mcause;

    // Single place where interrupt enables are applied
    assign irq_req = mstatus_mie && mie_meie && key_pending;

    // Read mux, unlisted numbers read zero
    always_comb begin
        csr_rdata = '0;
        case (csr_addr)
            `RV_CSR_MSTATUS: begin
                csr_rdata[3] = mstatus_mie;
                csr_rdata[7] = mstatus_mpie;
            end
            `RV_CSR_MIE:    csr_rdata[11] = mie_meie;
            `RV_CSR_MIP:    csr_rdata[11] = key_pending; // MEIP mirror
            `RV_CSR_MTVEC:  csr_rdata = {32'b0, mtvec};
            `RV_CSR_MEPC:   csr_rdata = {32'b0, mepc};
            `RV_CSR_MCAUSE: csr_rdata = mcause;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_meie     <= 1'b0;
            mtvec        <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else if (trap_enter) begin
            mepc         <= ir_pc;
            mcause       <= `RV_MCAUSE_MEI;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0; // Handler runs masked
        end else if (mret) begin
            mstatus_mie  <= mstatus_mpie;
        end else if (csr_we) begin
            case (csr_addr)
                `RV_CSR_MSTATUS: begin
                    mstatus_mie  <= csr_wdata[3];
                    mstatus_mpie <= csr_wdata[7];
                end
                `RV_CSR_MIE:    mie_meie <= csr_wdata[11];
                `RV_CSR_MTVEC:  mtvec <= {csr_wdata[31:2], 2'b00}; // Direct mode only
                `RV_CSR_MEPC:   mepc <= {csr_wdata[31:2], 2'b00};
                `RV_CSR_MCAUSE: mcause <= csr_wdata;
                default: ; // mip and unknown ignored
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_irq_seq.sv ====
`default_nettype none

`include "rv_config.svh"

module rv_irq_seq (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 irq_req,
    input  wire                 can_trap,
    input  wire rv_pkg::xword_t bus_read_data,
    input  wire                 art_credit,    // One per art entry drained
    output logic                stall,
    output logic                trap_enter,
    output rv_pkg::xword_t      bus_address,
    output rv_pkg::xword_t      bus_write_data,
    output logic                bus_write_enable,
    output logic                bus_read_enable
);

    rv_pkg::irq_state_t state;
    rv_pkg::irq_state_t state_next;
    rv_pkg::credit_t    credits;   // Free art FIFO slots as seen from here
    rv_pkg::xword_t     key_word;  // Captured key value
    logic               rd_valid;  // bus_read_data valid this cycle
    logic               start;

    assign start = (state == rv_pkg::IRQ_IDLE) && irq_req && can_trap;

    // Freeze the core already in the cycle the request is taken
    assign stall = start || (state != rv_pkg::IRQ_IDLE);

    assign trap_enter       = (state == rv_pkg::IRQ_ENTER);
    assign bus_read_enable  = (state == rv_pkg::IRQ_READ);
    assign bus_write_enable = (state == rv_pkg::IRQ_WRITE);
    assign bus_address      = (state == rv_pkg::IRQ_WRITE) ? `RV_ART_BASE : `RV_KEY_BASE;
    assign bus_write_data   = key_word;

    always_comb begin
        state_next = state;
        case (state)
            rv_pkg::IRQ_IDLE:        if (start) state_next = rv_pkg::IRQ_READ;
            rv_pkg::IRQ_READ:        state_next = rv_pkg::IRQ_WAIT_CREDIT;
            rv_pkg::IRQ_WAIT_CREDIT: if (credits != '0) state_next = rv_pkg::IRQ_WRITE;
            rv_pkg::IRQ_WRITE:       state_next = rv_pkg::IRQ_ENTER;
            rv_pkg::IRQ_ENTER:       state_next = rv_pkg::IRQ_IDLE;
            default:                 state_next = rv_pkg::IRQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= rv_pkg::IRQ_IDLE;
            rd_valid <= 1'b0;
            credits  <= rv_pkg::credit_t'(`RV_ART_DEPTH); // FIFO starts empty
        end else begin
            state    <= state_next;
            rd_valid <= bus_read_enable;
            // Spend and return may land together
            case ({bus_write_enable, art_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

    // Key value, taken one cycle after the read strobe
    always_ff @(posedge clk) begin
        if (rd_valid)
            key_word <= bus_read_data;
    end

endmodule

`default_nettype wire

// ==== hdl/rv_periph.sv ====
`default_nettype none

`include "rv_config.svh"

module rv_periph (
    input  wire                 clk,
    input  wire                 reset,
    input  wire rv_pkg::xword_t bus_address,
    input  wire rv_pkg::xword_t bus_write_data,
    input  wire                 bus_write_enable,
    input  wire                 bus_read_enable,
    input  wire                 key_valid,
    input  wire rv_pkg::xword_t key_data,
    input  wire                 art_take,
    output rv_pkg::xword_t      bus_read_data,
    output logic                key_pending,
    output logic                art_valid,
    output rv_pkg::xword_t      art_data,
    output logic                art_credit
);

    localparam int PTR_W = (`RV_ART_DEPTH > 1) ? $clog2(`RV_ART_DEPTH) : 1;

    rv_pkg::xword_t  key_reg;
    rv_pkg::xword_t  art_mem [`RV_ART_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    rv_pkg::credit_t count;     // Entries held
    logic            key_read;
    logic            push;
    logic            pop;

    assign key_read = bus_read_enable && (bus_address == `RV_KEY_BASE);
    assign push     = bus_write_enable && (bus_address == `RV_ART_BASE); // Sender holds a credit
    assign pop      = art_take && art_valid;

    assign art_valid = (count != '0);
    assign art_data  = art_mem[rd_ptr];

    // Key latch and bus read port
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            key_pending   <= 1'b0;
            bus_read_data <= '0;
        end else begin
            if (bus_read_enable)
                bus_read_data <= key_read ? key_reg : '0; // Other addresses read zero
            if (key_valid)
                key_pending <= 1'b1; // New key wins over a same-cycle read
            else if (key_read)
                key_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid)
            key_reg <= key_data;
        if (push)
            art_mem[wr_ptr] <= bus_write_data;
    end

    // Circular FIFO control
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            art_credit <= 1'b0;
        end else begin
            art_credit <= pop; // Slot freed, hand it back
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(`RV_ART_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`RV_ART_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_soc.sv ====
`default_nettype none

module rv_soc (
    input  wire                   clk,
    input  wire                   reset,
    input  wire rv_pkg::instr_t   instruction,
    output rv_pkg::pc_t           pc,
    output logic                  heartbeat,
    input  wire rv_pkg::reg_idx_t dbg_addr,
    output rv_pkg::xword_t        dbg_data,
    input  wire                   key_valid,
    input  wire rv_pkg::xword_t   key_data,
    output logic                  art_valid,
    output rv_pkg::xword_t        art_data,
    input  wire                   art_take
);

    // Core and CSR block
    rv_pkg::pc_t       ir_pc;
    rv_pkg::pc_t       mtvec;
    rv_pkg::pc_t       mepc;
    logic              can_trap;
    logic              csr_we;
    rv_pkg::csr_addr_t csr_addr;
    rv_pkg::xword_t    csr_wdata;
    rv_pkg::xword_t    csr_rdata;
    logic              mret;

    // Interrupt path
    logic              irq_req;
    logic              stall;
    logic              trap_enter;
    logic              key_pending;
    logic              art_credit;

    // Sequencer bus
    rv_pkg::xword_t    bus_address;
    rv_pkg::xword_t    bus_write_data;
    rv_pkg::xword_t    bus_read_data;
    logic              bus_write_enable;
    logic              bus_read_enable;

    rv_core u_core (
        .clk, .reset, .instruction, .stall, .trap_enter, .mtvec, .mepc, .csr_rdata,
        .dbg_addr, .pc, .ir_pc, .can_trap, .csr_we, .csr_addr, .csr_wdata, .mret,
        .dbg_data, .heartbeat
    );

    rv_csr u_csr (
        .clk, .reset, .csr_we, .csr_addr, .csr_wdata, .mret, .trap_enter, .ir_pc,
        .key_pending, .csr_rdata, .mtvec, .mepc, .irq_req
    );

    rv_irq_seq u_irq_seq (
        .clk, .reset, .irq_req, .can_trap, .bus_read_data, .art_credit, .stall,
        .trap_enter, .bus_address, .bus_write_data, .bus_write_enable, .bus_read_enable
    );

    rv_periph u_periph (
        .clk, .reset, .bus_address, .bus_write_data, .bus_write_enable, .bus_read_enable,
        .key_valid, .key_data, .art_take, .bus_read_data, .key_pending, .art_valid,
        .art_data, .art_credit
    );

endmodule

`default_nettype wire

// ==== verification/rv_sva.sv ====
`default_nettype none

`include "rv_config.svh"

module rv_sva (
    input wire                  clk,
    input wire                  reset,
    input wire rv_pkg::credit_t level,      // Credits held, or FIFO entries used
    input wire                  room,       // A write may land now
    input wire                  write,
    input wire                  stall,
    input wire                  trap_enter
);

    level_bound: assert property (@(posedge clk) disable iff (!reset)
        level <= rv_pkg::credit_t'(`RV_ART_DEPTH))
        else $error("level above art FIFO depth");

    write_needs_room: assert property (@(posedge clk) disable iff (!reset)
        write |-> room)
        else $error("art write without a free slot");

    // Once service starts the core stays frozen up to the trap pulse
    stall_until_enter: assert property (@(posedge clk) disable iff (!reset)
        stall && !trap_enter |=> stall)
        else $error("stall dropped before trap entry");

endmodule

bind rv_irq_seq rv_sva u_seq_sva (
    .clk,
    .reset,
    .level      (credits),
    .room       (credits != '0),
    .write      (bus_write_enable),
    .stall,
    .trap_enter
);

// Peripheral side only has the occupancy checks
bind rv_periph rv_sva u_periph_sva (
    .clk,
    .reset,
    .level      (count),
    .room       (count != rv_pkg::credit_t'(`RV_ART_DEPTH)),
    .write      (bus_write_enable && bus_address == `RV_ART_BASE),
    .stall      (1'b0),
    .trap_enter (1'b0)
);

`default_nettype wire

// ==== verification/rv_tb.sv ====
`default_nettype none

`include "rv_config.svh"

module rv_tb;

    localparam int             CLK_HALF   = 10;
    localparam rv_pkg::pc_t    HANDLER    = 32'h0000_0400; // mtvec written by the setup code
    localparam rv_pkg::pc_t    SETUP_END  = 32'd28;        // First address after setup
    localparam rv_pkg::instr_t NOP        = 32'h0000_0013; // ADDI x0, x0, 0
    localparam rv_pkg::instr_t MRET_INSN  = 32'h3020_0073;
    localparam int             DEPTH      = `RV_ART_DEPTH;
    // Six tests, the longest near 500 cycles with its 100-cycle waits
    localparam int             WATCHDOG_CYCLES = 2000;

    logic             clk;
    logic             reset;
    rv_pkg::instr_t   instruction;
    rv_pkg::pc_t      pc;
    logic             heartbeat;
    rv_pkg::reg_idx_t dbg_addr;
    rv_pkg::xword_t   dbg_data;
    logic             key_valid;
    rv_pkg::xword_t   key_data;
    logic             art_valid;
    rv_pkg::xword_t   art_data;
    logic             art_take;

    rv_pkg::instr_t imem [512]; // Word-addressed program store
    integer         seed;
    int             trap_count; // Handler entries since reset

    assign instruction = imem[pc[10:2]]; // Same-cycle fetch

    rv_soc UUT (
        .clk, .reset, .instruction, .pc, .heartbeat, .dbg_addr, .dbg_data,
        .key_valid, .key_data, .art_valid, .art_data, .art_take
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // pc sits on mtvec for exactly one cycle per trap
    always @(posedge clk or negedge reset) begin
        if (!reset)
            trap_count <= 0;
        else if (pc == HANDLER)
            trap_count <= trap_count + 1;
    end

    // RV32I/RV64I encodings
    function automatic rv_pkg::instr_t lui_insn(rv_pkg::reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic rv_pkg::instr_t addi_insn(rv_pkg::reg_idx_t rd, rv_pkg::reg_idx_t rs1,
                                                 logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic rv_pkg::instr_t add_insn(rv_pkg::reg_idx_t rd, rv_pkg::reg_idx_t rs1,
                                                rv_pkg::reg_idx_t rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic rv_pkg::instr_t csrrw_insn(rv_pkg::reg_idx_t rd, rv_pkg::csr_addr_t csr,
                                                  rv_pkg::reg_idx_t rs1);
        return {csr, rs1, 3'b001, rd, 7'b1110011};
    endfunction

    // Reference values per the RV64 spec
    function automatic rv_pkg::xword_t sext12(logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    function automatic rv_pkg::xword_t lui_value(logic [19:0] imm);
        return {{32{imm[19]}}, imm, 12'h000};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1; // Drive point
    endtask

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_xword(string name, rv_pkg::xword_t got, rv_pkg::xword_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(string name, rv_pkg::pc_t got, rv_pkg::pc_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic read_reg(rv_pkg::reg_idx_t idx, output rv_pkg::xword_t val);
        dbg_addr = idx;
        #1;
        val = dbg_data;
    endtask

    task automatic check_reg(rv_pkg::reg_idx_t idx, rv_pkg::xword_t exp);
        rv_pkg::xword_t val;
        read_reg(idx, val);
        check_xword($sformatf("x%0d", idx), val, exp);
    endtask

    task automatic place(rv_pkg::pc_t addr, rv_pkg::instr_t insn);
        imem[addr[10:2]] = insn;
    endtask

    // Reset held, memory cleared, mtvec/mie setup and handler loaded
    task automatic begin_test(bit with_mie);
        int i;
        reset     = 1'b0;
        key_valid = 1'b0;
        art_take  = 1'b0;
        dbg_addr  = '0;
        for (i = 0; i < 512; i++)
            imem[i] = NOP;
        place(0, addi_insn(1, 0, 12'h400));
        place(4, csrrw_insn(0, `RV_CSR_MTVEC, 1));
        place(8, lui_insn(2, 20'h00001));
        place(12, addi_insn(2, 2, 12'h800));          // x2 = MEIE bit
        place(16, csrrw_insn(0, `RV_CSR_MIE, 2));
        if (with_mie) begin
            place(20, addi_insn(3, 0, 12'h008));       // mstatus.MIE
            place(24, csrrw_insn(0, `RV_CSR_MSTATUS, 3));
        end
        place(HANDLER, csrrw_insn(30, `RV_CSR_MCAUSE, 0));
        place(HANDLER + 32'd4, csrrw_insn(31, `RV_CSR_MEPC, 0));
        place(HANDLER + 32'd8, csrrw_insn(0, `RV_CSR_MEPC, 31)); // Put mepc back
        place(HANDLER + 32'd12, MRET_INSN);
    endtask

    task automatic release_reset();
        repeat (4) next_cycle();
        reset = 1'b1;
    endtask

    task automatic wait_pc(rv_pkg::pc_t target, int limit);
        int n;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (pc !== target && n < limit);
        if (pc !== target) begin
            $display("pc did not reach %h within %0d cycles", target, limit);
            abort_run();
        end
    endtask

    task automatic wait_traps(int count, int limit, output bit seen);
        int n;
        n = 0;
        while (trap_count < count && n < limit) begin
            next_cycle();
            n++;
        end
        seen = (trap_count >= count);
    endtask

    task automatic send_key(rv_pkg::xword_t value);
        key_data  = value;
        key_valid = 1'b1;
        next_cycle();
        key_valid = 1'b0;
    endtask

    // Take the head entry of the art FIFO
    task automatic pop_art(output rv_pkg::xword_t value, input int limit);
        int n;
        n = 0;
        while (!art_valid && n < limit) begin
            next_cycle();
            n++;
        end
        if (!art_valid) begin
            $display("no art entry appeared within %0d cycles", limit);
            abort_run();
        end
        value    = art_data;
        art_take = 1'b1;
        next_cycle();
        art_take = 1'b0;
    endtask

    task automatic arith_program();
        rv_pkg::xword_t e11;
        rv_pkg::xword_t e12;
        logic           beat;
        begin_test(1'b0);
        place(28, lui_insn(11, 20'h80000));
        place(32, addi_insn(12, 11, 12'hFFF));
        place(36, add_insn(13, 11, 12));
        place(40, addi_insn(0, 11, 12'h005));   // Must be dropped
        place(44, lui_insn(14, 20'h12345));
        place(48, addi_insn(14, 14, 12'h678));
        release_reset();
        wait_pc(32'd56, 50);
        e11 = lui_value(20'h80000);
        e12 = e11 + sext12(12'hFFF);
        check_reg(0, '0);
        check_reg(11, e11);
        check_reg(12, e12);
        check_reg(13, e11 + e12);
        check_reg(14, lui_value(20'h12345) + sext12(12'h678));
        beat = heartbeat;
        next_cycle();
        if (heartbeat === beat) begin
            $display("heartbeat did not toggle");
            abort_run();
        end
    endtask

    task automatic csr_readback();
        begin_test(1'b0);
        place(28, addi_insn(3, 0, 12'h100));
        place(32, csrrw_insn(5, `RV_CSR_MTVEC, 3)); // Old mtvec out, new in
        place(36, csrrw_insn(6, `RV_CSR_MIE, 0));
        place(40, addi_insn(7, 0, 12'h001));
        place(44, csrrw_insn(7, 12'h7C0, 1));       // Not implemented
        place(48, csrrw_insn(8, `RV_CSR_MTVEC, 0));
        place(52, csrrw_insn(9, `RV_CSR_MIE, 0));
        release_reset();
        wait_pc(32'd60, 50);
        check_reg(5, 64'h400);
        check_reg(6, 64'h800);
        check_reg(7, '0);
        check_reg(8, 64'h100);
        check_reg(9, '0);
    endtask

    task automatic key_interrupt();
        rv_pkg::xword_t key;
        rv_pkg::xword_t epc;
        rv_pkg::xword_t art;
        begin_test(1'b1);
        release_reset();
        wait_pc(SETUP_END + 32'd8, 50);
        key = {$random(seed), $random(seed)};
        send_key(key);
        wait_pc(HANDLER, 50);
        wait_pc(HANDLER + 32'd16, 20);  // MRET in flight, handler regs written
        check_reg(30, `RV_MCAUSE_MEI);
        read_reg(31, epc);
        if (epc < SETUP_END || epc >= HANDLER || epc[1:0] != 2'b00) begin
            $display("mepc %h is not an address of the program", epc);
            abort_run();
        end
        wait_pc(epc[31:0], 20);         // Back at the interrupted instruction
        pop_art(art, 20);
        check_xword("art_data", art, key);
    endtask

    task automatic masked_interrupt();
        rv_pkg::xword_t key;
        rv_pkg::xword_t art;
        begin_test(1'b0);
        place(32'h180, addi_insn(3, 0, 12'h008)); // Late MIE enable
        place(32'h184, csrrw_insn(0, `RV_CSR_MSTATUS, 3));
        release_reset();
        wait_pc(SETUP_END + 32'd8, 50);
        key = {$random(seed), $random(seed)};
        send_key(key);
        repeat (50) begin
            next_cycle();
            if (art_valid || trap_count != 0) begin
                $display("key serviced while mstatus.MIE was clear");
                abort_run();
            end
        end
        wait_pc(HANDLER, 200);
        pop_art(art, 20);
        check_xword("art_data", art, key);
    endtask

    task automatic art_backpressure();
        rv_pkg::xword_t keys [DEPTH + 2];
        rv_pkg::xword_t art;
        bit             seen;
        int             i;
        begin_test(1'b1);
        release_reset();
        wait_pc(SETUP_END + 32'd8, 50);
        for (i = 0; i < DEPTH + 2; i++) begin
            keys[i] = {$random(seed), $random(seed)};
            send_key(keys[i]);
            wait_traps(i + 1, 100, seen);
            if (i < DEPTH && !seen) begin
                $display("trap %0d missing while credits remained", i);
                abort_run();
            end
            if (i >= DEPTH && seen) begin
                $display("trap %0d taken with the art FIFO full", i);
                abort_run();
            end
        end
        for (i = 0; i < DEPTH + 2; i++) begin
            pop_art(art, 200);
            check_xword($sformatf("art_data[%0d]", i), art, keys[i]);
        end
        wait_traps(DEPTH + 2, 200, seen);
        if (!seen) begin
            $display("held traps did not complete after draining");
            abort_run();
        end
    endtask

    // Short dependent chain with a non-idempotent step at 40
    task automatic trap_return();
        rv_pkg::xword_t e10;
        rv_pkg::xword_t e11;
        rv_pkg::xword_t e12;
        rv_pkg::xword_t epc;
        int             run;
        e10 = sext12(12'h005) + sext12(12'h003);
        e11 = e10 + e10;
        e10 = e10 + sext12(12'h003);
        e12 = e11 + e10;
        e11 = e11 + sext12(12'hFFF);
        for (run = 0; run < 2; run++) begin
            begin_test(1'b1);
            place(28, addi_insn(10, 0, 12'h005));
            place(32, addi_insn(10, 10, 12'h003));
            place(36, add_insn(11, 10, 10));
            place(40, addi_insn(10, 10, 12'h003));
            place(44, add_insn(12, 11, 10));
            place(48, addi_insn(11, 11, 12'hFFF));
            release_reset();
            if (run == 1) begin
                wait_pc(32'd40, 50);
                send_key({$random(seed), $random(seed)}); // Trap lands on address 40
            end
            wait_pc(32'd56, 100);
            if (trap_count != run) begin
                $display("expected %0d traps in run %0d, saw %0d", run, run, trap_count);
                abort_run();
            end
            check_reg(10, e10);
            check_reg(11, e11);
            check_reg(12, e12);
            if (run == 1) begin
                read_reg(31, epc);
                check_pc("mepc", epc[31:0], 32'd40);
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        seed      = 21;
        reset     = 1'b0;
        key_valid = 1'b0;
        key_data  = '0;
        art_take  = 1'b0;
        dbg_addr  = '0;
        arith_program();
        csr_readback();
        key_interrupt();
        masked_interrupt();
        art_backpressure();
        trap_return();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_core.sv
hdl/rv_csr.sv
hdl/rv_irq_seq.sv
hdl/rv_periph.sv
hdl/rv_soc.sv
verification/rv_sva.sv
verification/rv_tb.sv

// ==== Makefile ====
# Verilator build and run of the RV64 execution subsystem testbench

VERILATOR ?= verilator
TOP       ?= rv_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= sim passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Result check OK, see $(LOG)"; \
	else \
		echo "Result check FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
